// ==== logic/icache_pkg.sv ====
// Cache geometry and tag entry type shared by every instruction cache module
`default_nettype none

package icache_pkg;

  // Physical address space
  localparam int unsigned PHYS_ADDR_LEN = 56;

  // Associativity
  localparam int unsigned WAYS_WIDTH = 2;
  localparam int unsigned NUM_WAYS   = 2 ** WAYS_WIDTH;

  // Sets and line layout
  localparam int unsigned SETS_WIDTH   = 6;
  localparam int unsigned BEATS_WIDTH  = 3;
  localparam int unsigned LINE_BEATS   = 2 ** BEATS_WIDTH;
  localparam int unsigned BEAT_WIDTH   = 64;
  localparam int unsigned OFFSET_WIDTH = 6;

  localparam int unsigned TAG_WIDTH       = PHYS_ADDR_LEN - SETS_WIDTH - OFFSET_WIDTH;
  localparam int unsigned DATA_ADDR_WIDTH = SETS_WIDTH + BEATS_WIDTH;

  // One tag array entry
  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic                 valid;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== logic/icache_if.sv ====
// Array access and array write interfaces connecting the cache control, refill and flush blocks
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if;
  import icache_pkg::*;

  // Read side, address is {set, beat}
  logic [DATA_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_req_tag;
  logic                       rd_req_data;
  tag_entry_t                 rd_tag [NUM_WAYS];
  logic [BEAT_WIDTH-1:0]      rd_data [NUM_WAYS];

  // Write side
  logic                       wr_req_tag;
  logic                       wr_req_data;
  logic [NUM_WAYS-1:0]        wr_ways;
  logic [DATA_ADDR_WIDTH-1:0] wr_addr;
  tag_entry_t                 wr_tag;
  logic [BEAT_WIDTH-1:0]      wr_data;

  modport ctrl (
    output rd_addr, rd_req_tag, rd_req_data,
    output wr_req_tag, wr_req_data, wr_ways, wr_addr, wr_tag, wr_data,
    input  rd_tag, rd_data
  );

  modport array (
    input  rd_addr, rd_req_tag, rd_req_data,
    input  wr_req_tag, wr_req_data, wr_ways, wr_addr, wr_tag, wr_data,
    output rd_tag, rd_data
  );

endinterface

interface icache_wr_if;
  import icache_pkg::*;

  logic                       tag_req;
  logic                       data_req;
  logic [NUM_WAYS-1:0]        ways;
  logic [DATA_ADDR_WIDTH-1:0] addr;
  tag_entry_t                 tag;
  logic [BEAT_WIDTH-1:0]      data;

  modport writer (output tag_req, data_req, ways, addr, tag, data);

  modport sink (input tag_req, data_req, ways, addr, tag, data);

endinterface

`default_nettype wire

// ==== logic/icache_ram.sv ====
// One-read one-write synchronous RAM, used for both the tag and the data arrays
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
  parameter type         entry_t     = logic [7:0],
  parameter int unsigned DEPTH_WIDTH = 6
) (
  input  logic                   clk_i,

  input  logic                   rd_req_i,
  input  logic [DEPTH_WIDTH-1:0] rd_addr_i,
  output entry_t                 rd_data_o,

  input  logic                   wr_req_i,
  input  logic [DEPTH_WIDTH-1:0] wr_addr_i,
  input  entry_t                 wr_data_i
);

  entry_t mem_q [2 ** DEPTH_WIDTH];

  // Read data stays put until the next read request
  always_ff @(posedge clk_i) begin
    if (wr_req_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
    if (rd_req_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_arrays.sv ====
// Per-way tag and data storage with same-cycle write-to-read bypass
`timescale 1ns/1ps
`default_nettype none

module icache_arrays (
  input  logic      clk_i,
  input  logic      rst_ni,
  icache_array_if.array arr
);

  import icache_pkg::*;

  wire [SETS_WIDTH-1:0] rd_set = arr.rd_addr[DATA_ADDR_WIDTH-1:BEATS_WIDTH];
  wire [SETS_WIDTH-1:0] wr_set = arr.wr_addr[DATA_ADDR_WIDTH-1:BEATS_WIDTH];

  //////////////////////////////////////////////////
  // Bypass payload, shared by all ways
  //////////////////////////////////////////////////

  tag_entry_t            tag_byp_q;
  logic [BEAT_WIDTH-1:0] data_byp_q;

  always_ff @(posedge clk_i) begin
    if (arr.rd_req_tag) begin
      tag_byp_q <= arr.wr_tag;
    end
    if (arr.rd_req_data) begin
      data_byp_q <= arr.wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Ways
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
    logic                  tag_byp_valid_q;
    logic                  data_byp_valid_q;
    tag_entry_t            tag_raw;
    logic [BEAT_WIDTH-1:0] data_raw;

    // Flag a way whose location was written during the read cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_byp_valid_q  <= 1'b0;
        data_byp_valid_q <= 1'b0;
      end else begin
        if (arr.rd_req_tag) begin
          tag_byp_valid_q <= arr.wr_req_tag && arr.wr_ways[i] && (wr_set == rd_set);
        end
        if (arr.rd_req_data) begin
          data_byp_valid_q <= arr.wr_req_data && arr.wr_ways[i] &&
                              (arr.wr_addr == arr.rd_addr);
        end
      end
    end

    assign arr.rd_tag[i]  = tag_byp_valid_q ? tag_byp_q : tag_raw;
    assign arr.rd_data[i] = data_byp_valid_q ? data_byp_q : data_raw;

    icache_ram #(
      .entry_t     (tag_entry_t),
      .DEPTH_WIDTH (SETS_WIDTH)
    ) u_tag_ram (
      .clk_i     (clk_i),
      .rd_req_i  (arr.rd_req_tag),
      .rd_addr_i (rd_set),
      .rd_data_o (tag_raw),
      .wr_req_i  (arr.wr_req_tag && arr.wr_ways[i]),
      .wr_addr_i (wr_set),
      .wr_data_i (arr.wr_tag)
    );

    icache_ram #(
      .entry_t     (logic [BEAT_WIDTH-1:0]),
      .DEPTH_WIDTH (DATA_ADDR_WIDTH)
    ) u_data_ram (
      .clk_i     (clk_i),
      .rd_req_i  (arr.rd_req_data),
      .rd_addr_i (arr.rd_addr),
      .rd_data_o (data_raw),
      .wr_req_i  (arr.wr_req_data && arr.wr_ways[i]),
      .wr_addr_i (arr.wr_addr),
      .wr_data_i (arr.wr_data)
    );

    // The reset sweep must have reached every set before any tag is read
    a_tag_valid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arr.rd_req_tag |=> !$isunknown(arr.rd_tag[i].valid));
  end

endmodule

`default_nettype wire

// ==== logic/icache_refill.sv ====
// Line refill engine: requests a line from memory and writes its beats and tag into one way
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,

  input  logic                                                start_i,
  input  logic [icache_pkg::PHYS_ADDR_LEN-icache_pkg::OFFSET_WIDTH-1:0] line_addr_i,
  input  logic [icache_pkg::WAYS_WIDTH-1:0]                   way_i,
  icache_wr_if.writer                                         wr,

  output logic                                                mem_req_valid_o,
  input  logic                                                mem_req_ready_i,
  output logic [icache_pkg::PHYS_ADDR_LEN-1:0]                mem_req_addr_o,
  input  logic                                                mem_resp_valid_i,
  input  logic [icache_pkg::BEAT_WIDTH-1:0]                   mem_resp_data_i,
  input  logic                                                mem_resp_denied_i,

  output logic                                                done_o,
  output logic                                                denied_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQUEST,
    RF_PROGRESS,
    RF_COMPLETE
  } refill_state_e;

  refill_state_e                        state_q, state_d;
  logic [BEATS_WIDTH-1:0]               beat_q, beat_d;
  logic                                 denied_q, denied_d;
  logic [PHYS_ADDR_LEN-OFFSET_WIDTH-1:0] line_q;
  logic [WAYS_WIDTH-1:0]                way_q;

  wire last_beat = beat_q == BEATS_WIDTH'(LINE_BEATS - 1);

  assign mem_req_addr_o = {line_q, OFFSET_WIDTH'(0)};
  assign done_o         = state_q == RF_COMPLETE;
  assign denied_o       = denied_q;

  // Beats go to the chosen way, the tag goes in with the last beat
  assign wr.ways      = NUM_WAYS'(1) << way_q;
  assign wr.addr      = {line_q[SETS_WIDTH-1:0], beat_q};
  assign wr.data      = mem_resp_data_i;
  assign wr.tag.tag   = line_q[PHYS_ADDR_LEN-OFFSET_WIDTH-1:SETS_WIDTH];
  assign wr.tag.valid = 1'b1;

  always_comb begin
    state_d         = state_q;
    beat_d          = beat_q;
    denied_d        = 1'b0;
    mem_req_valid_o = 1'b0;
    wr.tag_req      = 1'b0;
    wr.data_req     = 1'b0;

    unique case (state_q)
      RF_IDLE: begin
        if (start_i) begin
          state_d = RF_REQUEST;
        end
      end
      RF_REQUEST: begin
        mem_req_valid_o = 1'b1;
        beat_d          = '0;
        if (mem_req_ready_i) begin
          state_d = RF_PROGRESS;
        end
      end
      RF_PROGRESS: begin
        if (mem_resp_valid_i) begin
          if (mem_resp_denied_i && beat_q == '0) begin
            // Denied transfer is a single beat and leaves the way untouched
            denied_d = 1'b1;
            state_d  = RF_IDLE;
          end else begin
            wr.data_req = 1'b1;
            wr.tag_req  = last_beat;
            beat_d      = beat_q + 1'b1;
            if (last_beat) begin
              state_d = RF_COMPLETE;
            end
          end
        end
      end
      default: begin
        state_d = RF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= RF_IDLE;
      beat_q   <= '0;
      denied_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      beat_q   <= beat_d;
      denied_q <= denied_d;
    end
  end

  // Line address and way are latched at start
  always_ff @(posedge clk_i) begin
    if (state_q == RF_IDLE && start_i) begin
      line_q <= line_addr_i;
      way_q  <= way_i;
    end
  end

  // Memory only returns beats for a request the refill has issued
  a_no_beat_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == RF_IDLE |-> !mem_resp_valid_i);

endmodule

`default_nettype wire

// ==== logic/icache_flush.sv ====
// Invalidation sweep over all sets and ways, run after reset and on a flush request
`timescale 1ns/1ps
`default_nettype none

module icache_flush (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  icache_wr_if.writer wr,
  output logic        done_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {
    FL_IDLE,
    FL_ARM,
    FL_SWEEP,
    FL_DONE
  } flush_state_e;

  flush_state_e         state_q, state_d;
  logic [SETS_WIDTH-1:0] set_q;

  // Invalid tag into every way of the current set
  assign wr.tag_req  = state_q == FL_SWEEP;
  assign wr.data_req = 1'b0;
  assign wr.ways     = '1;
  assign wr.addr     = {set_q, BEATS_WIDTH'(0)};
  assign wr.tag      = '0;
  assign wr.data     = '0;
  assign done_o      = state_q == FL_DONE;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FL_IDLE:  if (start_i) state_d = FL_SWEEP;
      FL_ARM:   state_d = FL_SWEEP;
      FL_SWEEP: if (&set_q) state_d = FL_DONE;
      default:  state_d = FL_IDLE;
    endcase
  end

  // Reset lands in the armed state so the sweep starts right after release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FL_ARM;
      set_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FL_SWEEP) begin
        set_q <= set_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
// Fetch FSM: checks requests, reads the arrays, detects hits, picks victims and responds
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,

  input  logic                                                req_valid_i,
  input  logic [63:0]                                         req_pc_i,
  input  logic                                                req_flush_i,
  output logic                                                resp_valid_o,
  output logic [31:0]                                         resp_instr_o,
  output logic                                                resp_exception_o,

  icache_array_if.ctrl                                        arr,
  icache_wr_if.sink                                           refill_wr,
  icache_wr_if.sink                                           flush_wr,

  output logic                                                refill_start_o,
  output logic [icache_pkg::PHYS_ADDR_LEN-icache_pkg::OFFSET_WIDTH-1:0] refill_line_addr_o,
  output logic [icache_pkg::WAYS_WIDTH-1:0]                   refill_way_o,
  input  logic                                                refill_done_i,
  input  logic                                                refill_denied_i,
  output logic                                                flush_start_o,
  input  logic                                                flush_done_i
);

  import icache_pkg::*;

  localparam int unsigned BEAT_SHIFT = OFFSET_WIDTH - BEATS_WIDTH;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_REPLAY,
    ST_FILL,
    ST_EXCEPTION,
    ST_FLUSH
  } ctrl_state_e;

  ctrl_state_e           state_q, state_d;
  logic [63:0]           address_q;
  logic [WAYS_WIDTH-1:0] evict_q;
  logic                  flush_fetch_q;
  logic [NUM_WAYS-1:0]   hit;
  logic [NUM_WAYS-1:0]   empty;
  logic [WAYS_WIDTH-1:0] hit_way;
  logic [BEAT_WIDTH-1:0] hit_data;

  // Upper bits beyond the physical space must be zero
  wire canonical = ~|req_pc_i[63:PHYS_ADDR_LEN-1];
  wire accept    = state_q == ST_IDLE && req_valid_i;

  //////////////////////////////////////////////////
  // Hit detection and victim choice
  //////////////////////////////////////////////////

  always_comb begin
    hit_way = evict_q;
    for (int i = 0; i < NUM_WAYS; i++) begin
      empty[i] = !arr.rd_tag[i].valid;
      hit[i]   = arr.rd_tag[i].valid &&
                 arr.rd_tag[i].tag == address_q[PHYS_ADDR_LEN-1:SETS_WIDTH+OFFSET_WIDTH];
    end
    // Hit beats lowest empty way beats round-robin
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (empty[i]) hit_way = WAYS_WIDTH'(i);
    end
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (hit[i]) hit_way = WAYS_WIDTH'(i);
    end
  end

  assign hit_data     = arr.rd_data[hit_way];
  assign resp_instr_o = address_q[2] ? hit_data[63:32] : hit_data[31:0];

  assign refill_line_addr_o = address_q[PHYS_ADDR_LEN-1:OFFSET_WIDTH];
  assign refill_way_o       = hit_way;

  // Array reads on a new request or on replay
  assign arr.rd_addr = (state_q == ST_REPLAY) ? address_q[BEAT_SHIFT +: DATA_ADDR_WIDTH]
                                              : req_pc_i[BEAT_SHIFT +: DATA_ADDR_WIDTH];

  //////////////////////////////////////////////////
  // Main FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    resp_valid_o     = 1'b0;
    resp_exception_o = 1'b0;
    refill_start_o   = 1'b0;
    flush_start_o    = 1'b0;
    arr.rd_req_tag   = 1'b0;
    arr.rd_req_data  = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          if (!canonical) begin
            state_d = ST_EXCEPTION;
          end else if (req_flush_i) begin
            flush_start_o = 1'b1;
            state_d       = ST_FLUSH;
          end else begin
            arr.rd_req_tag  = 1'b1;
            arr.rd_req_data = 1'b1;
            state_d         = ST_FETCH;
          end
        end
      end
      ST_FETCH: begin
        if (|hit) begin
          resp_valid_o = 1'b1;
          state_d      = ST_IDLE;
        end else begin
          refill_start_o = 1'b1;
          state_d        = ST_FILL;
        end
      end
      ST_REPLAY: begin
        arr.rd_req_tag  = 1'b1;
        arr.rd_req_data = 1'b1;
        state_d         = ST_FETCH;
      end
      ST_FILL: begin
        if (refill_denied_i) begin
          resp_valid_o     = 1'b1;
          resp_exception_o = 1'b1;
          state_d          = ST_IDLE;
        end else if (refill_done_i) begin
          state_d = ST_REPLAY;
        end
      end
      ST_EXCEPTION: begin
        resp_valid_o     = 1'b1;
        resp_exception_o = 1'b1;
        state_d          = ST_IDLE;
      end
      default: begin
        // Flush; the reset sweep ends without a fetch
        if (flush_done_i) begin
          state_d = flush_fetch_q ? ST_REPLAY : ST_IDLE;
        end
      end
    endcase
  end

  // Write port follows whichever writer the current state owns
  always_comb begin
    arr.wr_req_tag  = 1'b0;
    arr.wr_req_data = 1'b0;
    arr.wr_ways     = '0;
    arr.wr_addr     = '0;
    arr.wr_tag      = '0;
    arr.wr_data     = '0;
    if (state_q == ST_FILL) begin
      arr.wr_req_tag  = refill_wr.tag_req;
      arr.wr_req_data = refill_wr.data_req;
      arr.wr_ways     = refill_wr.ways;
      arr.wr_addr     = refill_wr.addr;
      arr.wr_tag      = refill_wr.tag;
      arr.wr_data     = refill_wr.data;
    end else if (state_q == ST_FLUSH) begin
      arr.wr_req_tag  = flush_wr.tag_req;
      arr.wr_req_data = flush_wr.data_req;
      arr.wr_ways     = flush_wr.ways;
      arr.wr_addr     = flush_wr.addr;
      arr.wr_tag      = flush_wr.tag;
      arr.wr_data     = flush_wr.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_FLUSH;
      evict_q       <= '0;
      flush_fetch_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Round-robin pointer moves only when it supplied the victim
      if (state_q == ST_FETCH && !(|hit) && !(|empty)) begin
        evict_q <= evict_q + 1'b1;
      end
      if (accept && canonical && req_flush_i) begin
        flush_fetch_q <= 1'b1;
      end else if (state_q == ST_FLUSH && flush_done_i) begin
        flush_fetch_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      address_q <= req_pc_i;
    end
  end

  // CPU keeps at most one fetch outstanding
  a_req_only_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> state_q == ST_IDLE);

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
// Instruction cache top level joining control, storage, refill and flush to CPU and memory
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // CPU port
  input  logic                                req_valid_i,
  input  logic [63:0]                         req_pc_i,
  input  logic                                req_flush_i,
  output logic                                resp_valid_o,
  output logic [31:0]                         resp_instr_o,
  output logic                                resp_exception_o,

  // Memory port
  output logic                                mem_req_valid_o,
  input  logic                                mem_req_ready_i,
  output logic [icache_pkg::PHYS_ADDR_LEN-1:0] mem_req_addr_o,
  input  logic                                mem_resp_valid_i,
  input  logic [icache_pkg::BEAT_WIDTH-1:0]   mem_resp_data_i,
  input  logic                                mem_resp_denied_i
);

  import icache_pkg::*;

  icache_array_if u_arr_if ();
  icache_wr_if    u_refill_wr ();
  icache_wr_if    u_flush_wr ();

  logic                                  refill_start;
  logic [PHYS_ADDR_LEN-OFFSET_WIDTH-1:0] refill_line_addr;
  logic [WAYS_WIDTH-1:0]                 refill_way;
  logic                                  refill_done;
  logic                                  refill_denied;
  logic                                  flush_start;
  logic                                  flush_done;

  icache_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_valid_i        (req_valid_i),
    .req_pc_i           (req_pc_i),
    .req_flush_i        (req_flush_i),
    .resp_valid_o       (resp_valid_o),
    .resp_instr_o       (resp_instr_o),
    .resp_exception_o   (resp_exception_o),
    .arr                (u_arr_if.ctrl),
    .refill_wr          (u_refill_wr.sink),
    .flush_wr           (u_flush_wr.sink),
    .refill_start_o     (refill_start),
    .refill_line_addr_o (refill_line_addr),
    .refill_way_o       (refill_way),
    .refill_done_i      (refill_done),
    .refill_denied_i    (refill_denied),
    .flush_start_o      (flush_start),
    .flush_done_i       (flush_done)
  );

  icache_arrays u_arrays (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (u_arr_if.array)
  );

  icache_refill u_refill (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (refill_start),
    .line_addr_i       (refill_line_addr),
    .way_i             (refill_way),
    .wr                (u_refill_wr.writer),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_ready_i   (mem_req_ready_i),
    .mem_req_addr_o    (mem_req_addr_o),
    .mem_resp_valid_i  (mem_resp_valid_i),
    .mem_resp_data_i   (mem_resp_data_i),
    .mem_resp_denied_i (mem_resp_denied_i),
    .done_o            (refill_done),
    .denied_o          (refill_denied)
  );

  icache_flush u_flush (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (flush_start),
    .wr      (u_flush_wr.writer),
    .done_o  (flush_done)
  );

endmodule

`default_nettype wire

// ==== bench/icache_mem_model.sv ====
// Memory responder for the instruction cache bench, returns computed beats with random gaps
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
  parameter logic [31:0] MIX      = 32'h5a3c_96e1,
  parameter logic [31:0] GEN_MIX  = 32'h9e37_79b9,
  parameter int unsigned DENY_BIT = 40,
  parameter logic [31:0] SEED     = 32'h0000_0001
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [7:0]                           gen_i,
  input  logic                                 req_valid_i,
  input  logic [icache_pkg::PHYS_ADDR_LEN-1:0] req_addr_i,
  output logic                                 req_ready_o,
  output logic                                 resp_valid_o,
  output logic [icache_pkg::BEAT_WIDTH-1:0]    resp_data_o,
  output logic                                 resp_denied_o
);

  import icache_pkg::*;

  logic [PHYS_ADDR_LEN-1:0] line_addr;
  logic [PHYS_ADDR_LEN-1:0] beat_addr;
  int unsigned              num_beats;

  // Word content is its byte address folded to 32 bits and mixed with the generation
  function automatic logic [31:0] mem_word(input logic [PHYS_ADDR_LEN-1:0] addr,
                                           input logic [7:0] gen);
    return addr[31:0] ^ 32'(addr[PHYS_ADDR_LEN-1:32]) ^ MIX ^ (32'(gen) * GEN_MIX);
  endfunction

  initial begin
    req_ready_o   = 1'b0;
    resp_valid_o  = 1'b0;
    resp_data_o   = '0;
    resp_denied_o = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(negedge clk_i);
      if (rst_ni && req_valid_i) begin
        repeat ($urandom % 4) @(negedge clk_i);
        req_ready_o = 1'b1;
        line_addr   = req_addr_i;
        @(negedge clk_i);
        req_ready_o = 1'b0;
        // A denied line answers with one beat only
        num_beats = line_addr[DENY_BIT] ? 1 : LINE_BEATS;
        for (int b = 0; b < num_beats; b++) begin
          repeat ($urandom % 4) @(negedge clk_i);
          beat_addr     = line_addr + PHYS_ADDR_LEN'(b * 8);
          resp_valid_o  = 1'b1;
          resp_denied_o = line_addr[DENY_BIT];
          resp_data_o   = {mem_word(beat_addr + 4, gen_i), mem_word(beat_addr, gen_i)};
          @(negedge clk_i);
          resp_valid_o  = 1'b0;
          resp_denied_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_icache.sv ====
// Testbench for the instruction cache, runs the fetch scenarios and checks them with assertions
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam logic [31:0] MIX           = 32'h5a3c_96e1;
  localparam logic [31:0] GEN_MIX       = 32'h9e37_79b9;
  localparam int unsigned DENY_BIT      = 40;
  localparam logic [31:0] SEED          = 32'h01b5397a;
  localparam int unsigned NUM_TESTS     = 6;
  localparam int unsigned RESP_TIMEOUT  = 1000;
  localparam longint      WATCHDOG_NS   = (NUM_TESTS * 2000 + 16 + 70) * 100;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_valid_i;
  logic [63:0]              req_pc_i;
  logic                     req_flush_i;
  logic                     resp_valid_o;
  logic [31:0]              resp_instr_o;
  logic                     resp_exception_o;
  logic                     mem_req_valid_o;
  logic                     mem_req_ready_i;
  logic [PHYS_ADDR_LEN-1:0] mem_req_addr_o;
  logic                     mem_resp_valid_i;
  logic [BEAT_WIDTH-1:0]    mem_resp_data_i;
  logic                     mem_resp_denied_i;

  // Reference state of the fetch in flight
  logic [7:0]               gen;
  logic [31:0]              exp_instr;
  logic                     exp_exc;
  logic [PHYS_ADDR_LEN-1:0] exp_line_addr;
  logic                     fast_q;
  logic                     no_mem_q;
  logic                     pending;
  int unsigned              errors;
  int unsigned              test_start_errors;
  int unsigned              tests_run;
  int unsigned              tests_failed;

  always #50 clk_i = ~clk_i;

  icache_top UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_pc_i          (req_pc_i),
    .req_flush_i       (req_flush_i),
    .resp_valid_o      (resp_valid_o),
    .resp_instr_o      (resp_instr_o),
    .resp_exception_o  (resp_exception_o),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_ready_i   (mem_req_ready_i),
    .mem_req_addr_o    (mem_req_addr_o),
    .mem_resp_valid_i  (mem_resp_valid_i),
    .mem_resp_data_i   (mem_resp_data_i),
    .mem_resp_denied_i (mem_resp_denied_i)
  );

  icache_mem_model #(
    .MIX      (MIX),
    .GEN_MIX  (GEN_MIX),
    .DENY_BIT (DENY_BIT),
    .SEED     (SEED)
  ) u_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .gen_i         (gen),
    .req_valid_i   (mem_req_valid_o),
    .req_addr_i    (mem_req_addr_o),
    .req_ready_o   (mem_req_ready_i),
    .resp_valid_o  (mem_resp_valid_i),
    .resp_data_o   (mem_resp_data_i),
    .resp_denied_o (mem_resp_denied_i)
  );

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !resp_valid_o && !mem_req_valid_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: activity during reset", $time);
    end

  a_resp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> pending)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: response with no request", $time);
    end

  a_exc_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_exception_o == exp_exc)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: exception flag wrong", $time);
    end

  a_instr_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !exp_exc |-> resp_instr_o == exp_instr)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: instr %h expected %h", $time, resp_instr_o, exp_instr);
    end

  a_fast_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && fast_q |=> resp_valid_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: response not after 1 cycle", $time);
    end

  a_no_mem_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    no_mem_q |-> !mem_req_valid_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: memory request on bad pc", $time);
    end

  a_line_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> mem_req_addr_o == exp_line_addr)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: line address %h expected %h", $time,
               mem_req_addr_o, exp_line_addr);
    end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] expected_word(input logic [63:0] pc, input logic [7:0] g);
    logic [63:0] byte_addr;
    byte_addr = {pc[63:2], 2'b00};
    return byte_addr[31:0] ^ {8'h00, byte_addr[55:32]} ^ MIX ^ (32'(g) * GEN_MIX);
  endfunction

  // One request strobe, then wait for the response
  task automatic fetch(input logic [63:0] pc, input logic flush, input logic hit);
    logic        canonical;
    int unsigned cycles;
    canonical     = ~|pc[63:PHYS_ADDR_LEN-1];
    exp_exc       = !canonical || pc[DENY_BIT];
    exp_instr     = expected_word(pc, gen);
    exp_line_addr = {pc[PHYS_ADDR_LEN-1:OFFSET_WIDTH], OFFSET_WIDTH'(0)};
    fast_q        = hit || !canonical;
    no_mem_q      = !canonical;
    pending       = 1'b1;
    req_valid_i   = 1'b1;
    req_pc_i      = pc;
    req_flush_i   = flush;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_flush_i = 1'b0;
    cycles      = 0;
    while (!resp_valid_o && cycles < RESP_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!resp_valid_o) begin
      errors++;
      $display("No response for pc %h within %0d cycles", pc, RESP_TIMEOUT);
    end
    @(negedge clk_i);
    pending  = 1'b0;
    no_mem_q = 1'b0;
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_start_errors) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name,
             (errors == test_start_errors) ? "passed" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_pc_i      = '0;
    req_flush_i   = 1'b0;
    gen           = 8'd0;
    exp_instr     = '0;
    exp_exc       = 1'b0;
    exp_line_addr = '0;
    fast_q        = 1'b0;
    no_mem_q      = 1'b0;
    pending       = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    // Reset sweep runs before the first request
    repeat (70) @(negedge clk_i);

    begin_test();
    fetch(64'h0000_0000_1000_0104, 1'b0, 1'b0);
    fetch(64'h0000_0000_1000_0104, 1'b0, 1'b1);
    end_test("miss then hit");

    begin_test();
    fetch(64'h0000_0000_1000_0208, 1'b0, 1'b0);
    fetch(64'h0000_0000_1000_020c, 1'b0, 1'b1);
    end_test("word select");

    begin_test();
    fetch(64'h0080_0000_0000_0100, 1'b0, 1'b0);
    fetch(64'h8000_0000_1000_0100, 1'b0, 1'b0);
    end_test("non-canonical pc");

    begin_test();
    fetch(64'h0000_0100_0000_0400, 1'b0, 1'b0);
    fetch(64'h0000_0000_1000_0404, 1'b0, 1'b0);
    end_test("denied refill");

    // Five lines in set 42 overflow the four ways
    begin_test();
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 5; k++) begin
        fetch(64'h0000_0000_2000_0a80 + 64'(k) * 64'h1000 + 64'(k * 4), 1'b0, 1'b0);
      end
    end
    end_test("replacement");

    begin_test();
    gen = 8'd1;
    fetch(64'h0000_0000_1000_0104, 1'b1, 1'b0);
    fetch(64'h0000_0000_1000_020c, 1'b0, 1'b0);
    end_test("flush");

    $display("tests run %0d, tests failed %0d, check failures %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the test count
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/icache_pkg.sv
logic/icache_if.sv
logic/icache_ram.sv
logic/icache_arrays.sv
logic/icache_refill.sv
logic/icache_flush.sv
logic/icache_ctrl.sv
logic/icache_top.sv
bench/icache_mem_model.sv
bench/tb_icache.sv
